// File: design/spi_loop_config.svh
`ifndef SPI_LOOP_CONFIG_SVH
`define SPI_LOOP_CONFIG_SVH

// build-wide constants for the spi loopback

// bits per transfer
// one chip select, msb first, fixed word
`define SPI_WIDTH 8

// clk cycles per sclk half period
// keep at 4 or more, slave sees pins through
// a 2-flop synchronizer plus edge detect (3 cycles)
`define SPI_HALF_PERIOD 4

// full transfer, send to data_valid:
//   16 * SPI_HALF_PERIOD + 2 clk cycles
// one half period of setup, 8 high halves,
// 7 low halves, then the finish cycle

`endif

// File: design/spi_loop_pkg.sv
package spi_loop_pkg;

  // master sequencer states
  // idle      waiting for send, cs high, sclk low
  // setup     cs low, first bit on mosi, sclk still low
  // sclk_high sclk high, miso sampled on entry
  // sclk_low  sclk low, next mosi bit on entry
  // finish    cs released, data_valid pulse
  typedef enum logic [2:0] {
    st_idle      = 3'd0,
    st_setup     = 3'd1,
    st_sclk_high = 3'd2,
    st_sclk_low  = 3'd3,
    st_finish    = 3'd4
  } master_state_e;

  // slave reply order
  // direct returns the received byte as is
  // reverse returns it with bit 0 swapped to the msb end
  typedef enum logic {
    order_direct  = 1'b0,
    order_reverse = 1'b1
  } reply_order_e;

  // reply is prepared at the end of one transfer
  // and shifted out during the next one,
  // so the master always reads the previous byte back

  // first transfer after reset
  // returns the cleared reply register, all zeros

  // no back-pressure anywhere
  // sends outside st_idle are dropped by the master

endpackage

// File: design/spi_master.sv
`include "spi_loop_config.svh"

module spi_master
  import spi_loop_pkg::*;
(
  input  logic                  clk,
  input  logic                  RST,
  input  logic                  send,
  input  logic [`SPI_WIDTH-1:0] data_in,
  output logic [`SPI_WIDTH-1:0] data_out,
  output logic                  data_valid,
  output logic                  mosi,
  input  logic                  miso,
  output logic                  sclk,
  output logic                  cs
);

  localparam int W   = `SPI_WIDTH;
  localparam int HCW = $clog2(`SPI_HALF_PERIOD);
  localparam int BCW = $clog2(`SPI_WIDTH);

  // last count of a half period
  localparam logic [HCW-1:0] HALF_LAST = HCW'(`SPI_HALF_PERIOD - 1);
  // index of the final bit
  localparam logic [BCW-1:0] BIT_LAST  = BCW'(`SPI_WIDTH - 1);

  master_state_e  state;
  logic [HCW-1:0] half_cnt;
  logic [BCW-1:0] bit_cnt;
  logic [W-1:0]   tx_shift;
  logic [W-1:0]   rx_shift;
  logic           half_done;

  // end of current half period
  assign half_done = (half_cnt == HALF_LAST);

  // msb first, tx_shift moves on falling sclk
  assign mosi = tx_shift[W-1];

  always_ff @(posedge clk) begin
    if (RST) begin
      state      <= st_idle;
      half_cnt   <= '0;
      bit_cnt    <= '0;
      sclk       <= 1'b0;
      cs         <= 1'b1;
      data_valid <= 1'b0;
      tx_shift   <= '0;
    end else begin
      // strobe by default
      data_valid <= 1'b0;
      case (state)
        st_idle: begin
          // sends only accepted here
          if (send) begin
            tx_shift <= data_in;
            cs       <= 1'b0;
            half_cnt <= '0;
            bit_cnt  <= '0;
            state    <= st_setup;
          end
        end
        // setup and low halves both end in a rising sclk
        st_setup, st_sclk_low: begin
          if (half_done) begin
            sclk     <= 1'b1;
            // mode 0 sample on rising edge
            rx_shift <= {rx_shift[W-2:0], miso};
            half_cnt <= '0;
            state    <= st_sclk_high;
          end else begin
            half_cnt <= half_cnt + 1'b1;
          end
        end
        st_sclk_high: begin
          if (half_done) begin
            sclk     <= 1'b0;
            half_cnt <= '0;
            if (bit_cnt == BIT_LAST) begin
              // last falling edge, release cs with it
              cs    <= 1'b1;
              state <= st_finish;
            end else begin
              // next bit onto mosi
              bit_cnt  <= bit_cnt + 1'b1;
              tx_shift <= {tx_shift[W-2:0], 1'b0};
              state    <= st_sclk_low;
            end
          end else begin
            half_cnt <= half_cnt + 1'b1;
          end
        end
        st_finish: begin
          // hand back what the slave sent
          data_out   <= rx_shift;
          data_valid <= 1'b1;
          state      <= st_idle;
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // clock parked low whenever the slave is deselected
  a_sclk_idle_low : assert property (
    @(posedge clk) disable iff (RST) cs |-> !sclk
  );

  // one pulse per transfer, never stretched
  a_valid_single : assert property (
    @(posedge clk) disable iff (RST) data_valid |=> !data_valid
  );

endmodule

// File: design/spi_slave.sv
`include "spi_loop_config.svh"

module spi_slave
  import spi_loop_pkg::*;
(
  input  logic         clk,
  input  logic         RST,
  input  reply_order_e select,
  input  logic         mosi,
  input  logic         sclk,
  input  logic         cs,
  output logic         miso
);

  localparam int W   = `SPI_WIDTH;
  localparam int RCW = $clog2(`SPI_WIDTH) + 1;

  // 2-flop synchronizers, [1] is the usable stage
  logic [1:0]     mosi_sync;
  logic [1:0]     sclk_sync;
  logic [1:0]     cs_sync;
  // previous synchronized levels for edge detect
  logic           sclk_q;
  logic           cs_q;
  logic           sclk_rise;
  logic           sclk_fall;
  logic           cs_fall;
  logic           cs_rise;
  logic           cs_low;
  logic [RCW-1:0] rise_cnt;
  logic [W-1:0]   rx_shift;
  logic [W-1:0]   rx_rev;
  logic [W-1:0]   tx_shift;
  logic [W-1:0]   reply;
  reply_order_e   order_q;

  always_ff @(posedge clk) begin
    if (RST) begin
      mosi_sync <= '0;
      sclk_sync <= '0;
      cs_sync   <= '1;
      sclk_q    <= 1'b0;
      cs_q      <= 1'b1;
    end else begin
      mosi_sync <= {mosi_sync[0], mosi};
      sclk_sync <= {sclk_sync[0], sclk};
      cs_sync   <= {cs_sync[0], cs};
      sclk_q    <= sclk_sync[1];
      cs_q      <= cs_sync[1];
    end
  end

  // edges, 3 clk behind the pins
  assign sclk_rise = sclk_sync[1] & ~sclk_q;
  assign sclk_fall = ~sclk_sync[1] & sclk_q;
  assign cs_fall   = ~cs_sync[1] & cs_q;
  assign cs_rise   = cs_sync[1] & ~cs_q;
  assign cs_low    = ~cs_sync[1];

  // mirrored copy of the received byte
  always_comb begin
    for (int i = 0; i < W; i++) begin
      rx_rev[i] = rx_shift[W-1-i];
    end
  end

  // reply msb first
  assign miso = tx_shift[W-1];

  always_ff @(posedge clk) begin
    if (RST) begin
      tx_shift <= '0;
      reply    <= '0;
      rise_cnt <= '0;
      order_q  <= order_direct;
    end else begin
      if (cs_fall) begin
        // first reply bit out as soon as cs is seen low
        tx_shift <= reply;
        rise_cnt <= '0;
        // order fixed for the whole transfer
        order_q  <= select;
      end else if (cs_low) begin
        // extra clocks past the word are not shifted in
        if (sclk_rise && (rise_cnt < RCW'(W))) begin
          rx_shift <= {rx_shift[W-2:0], mosi_sync[1]};
          rise_cnt <= rise_cnt + 1'b1;
        end
        // next reply bit on falling sclk
        if (sclk_fall) begin
          tx_shift <= {tx_shift[W-2:0], 1'b0};
        end
      end
      // end of transfer, prepare reply for the next one
      if (cs_rise) begin
        reply <= (order_q == order_reverse) ? rx_rev : rx_shift;
      end
    end
  end

  // master must not clock more than one word per select window
  a_word_length : assert property (
    @(posedge clk) disable iff (RST)
      (sclk_rise && cs_low) |-> (rise_cnt < RCW'(W))
  );

endmodule

// File: design/spi_loop.sv
`include "spi_loop_config.svh"

module spi_loop
  import spi_loop_pkg::*;
(
  input  logic                  clk,
  input  logic                  RST,
  input  logic                  send,
  input  logic [`SPI_WIDTH-1:0] data_in,
  output logic [`SPI_WIDTH-1:0] data_out,
  output logic                  data_valid,
  input  reply_order_e          select,
  // 1 routes master to slave internally, 0 uses the pins
  input  logic                  loop_mode,

  // master side pins
  output logic                  ext_master_mosi,
  input  logic                  ext_master_miso,
  output logic                  ext_master_sclk,
  output logic                  ext_master_cs,

  // slave side pins
  input  logic                  ext_slave_mosi,
  output logic                  ext_slave_miso,
  input  logic                  ext_slave_sclk,
  input  logic                  ext_slave_cs
);

  logic master_mosi;
  logic master_miso;
  logic master_sclk;
  logic master_cs;
  logic slave_mosi;
  logic slave_miso;
  logic slave_sclk;
  logic slave_cs;

  // master always drives its pins
  assign ext_master_mosi = master_mosi;
  assign ext_master_sclk = master_sclk;
  assign ext_master_cs   = master_cs;

  // master miso from slave or from outside
  assign master_miso = loop_mode ? slave_miso : ext_master_miso;

  // slave inputs from master wires or from outside
  assign slave_mosi = loop_mode ? master_mosi : ext_slave_mosi;
  assign slave_sclk = loop_mode ? master_sclk : ext_slave_sclk;
  assign slave_cs   = loop_mode ? master_cs   : ext_slave_cs;

  // slave reply always visible on its pin
  assign ext_slave_miso = slave_miso;

  spi_master master_i (
    .clk        (clk),
    .RST        (RST),
    .send       (send),
    .data_in    (data_in),
    .data_out   (data_out),
    .data_valid (data_valid),
    .mosi       (master_mosi),
    .miso       (master_miso),
    .sclk       (master_sclk),
    .cs         (master_cs)
  );

  // reply register lives here, survives loop_mode changes
  spi_slave slave_i (
    .clk    (clk),
    .RST    (RST),
    .select (select),
    .mosi   (slave_mosi),
    .sclk   (slave_sclk),
    .cs     (slave_cs),
    .miso   (slave_miso)
  );

endmodule

// File: tb/spi_loop_checker.sv
`include "spi_loop_config.svh"

module spi_loop_checker
  import spi_loop_pkg::*;
(
  input  logic                  clk,
  input  logic                  RST,
  input  logic                  data_valid,
  input  logic [`SPI_WIDTH-1:0] data_out,
  // master sequencer state, context for messages
  input  master_state_e         master_state,
  // one strobe per transfer started by the testbench
  input  logic                  exp_push,
  input  logic [`SPI_WIDTH-1:0] exp_data,
  input  logic [8*16-1:0]       exp_name,
  input  int                    exp_index,
  // end of stimulus, nothing should be left pending
  input  logic                  final_check,
  output int                    error_count,
  output int                    check_count
);

  localparam int W = `SPI_WIDTH;
  // send strobe to data_valid, counted from the send cycle
  localparam int LATENCY = 16 * `SPI_HALF_PERIOD + 2;

  // testbench strobes retimed to the rising edge
  logic            push_r;
  logic [W-1:0]    data_r;
  logic [8*16-1:0] name_r;
  int              index_r;
  logic            final_r;

  // expectations in send order
  logic [W-1:0]    exp_q[$];
  logic [8*16-1:0] name_q[$];
  int              index_q[$];

  // head of the queue while comparing
  logic [W-1:0]    exp_byte;
  logic [8*16-1:0] exp_nm;
  int              exp_idx;

  // falling edges seen, cycle stamp for each send
  int              tick;
  int              start_q[$];
  int              exp_start;

  // last returned byte, must hold between strobes
  logic [W-1:0]    held_out;
  logic            held_seen;

  initial begin
    error_count = 0;
    check_count = 0;
    tick        = 0;
    held_seen   = 1'b0;
  end

  always @(posedge clk) begin
    push_r  <= exp_push;
    data_r  <= exp_data;
    name_r  <= exp_name;
    index_r <= exp_index;
    final_r <= final_check;
  end

  // dut outputs are settled at the falling edge
  always @(negedge clk) begin
    tick = tick + 1;
    if (push_r) begin
      exp_q.push_back(data_r);
      name_q.push_back(name_r);
      index_q.push_back(index_r);
      // send was driven one cycle before the retimed strobe
      start_q.push_back(tick - 1);
    end
    if (!RST && data_valid === 1'b1) begin
      if (exp_q.size() == 0) begin
        // pulse with no send behind it
        $display("unexpected data_valid with data_out %02h, no transfer was pending (master %s)",
                 data_out, master_state.name());
        error_count = error_count + 1;
      end else begin
        exp_byte  = exp_q.pop_front();
        exp_nm    = name_q.pop_front();
        exp_idx   = index_q.pop_front();
        exp_start = start_q.pop_front();
        check_count = check_count + 1;
        if (data_out !== exp_byte) begin
          $display("Error %0s #%0d: expected %02h, actual %02h (master %s)",
                   exp_nm, exp_idx, exp_byte, data_out, master_state.name());
          error_count = error_count + 1;
        end
        // fixed sequencer length, send to strobe
        if (tick - exp_start != LATENCY) begin
          $display("Error %0s #%0d latency: expected %0d cycles, actual %0d",
                   exp_nm, exp_idx, LATENCY, tick - exp_start);
          error_count = error_count + 1;
        end
      end
      held_out  = data_out;
      held_seen = 1'b1;
    end else if (held_seen && data_out !== held_out) begin
      // data_out only moves together with data_valid
      $display("data_out changed from %02h to %02h with no data_valid (master %s)",
               held_out, data_out, master_state.name());
      error_count = error_count + 1;
      held_out    = data_out;
    end
    // sends that never produced a data_valid
    if (final_r && exp_q.size() != 0) begin
      $display("%0d transfer(s) never returned data_valid, first missing is %0s #%0d",
               exp_q.size(), name_q[0], index_q[0]);
      error_count = error_count + exp_q.size();
      exp_q.delete();
      name_q.delete();
      index_q.delete();
      start_q.delete();
    end
  end

endmodule

// File: tb/tb_spi_loop.sv
`include "spi_loop_config.svh"

module tb_spi_loop
  import spi_loop_pkg::*;
();

  localparam int W            = `SPI_WIDTH;
  localparam int RESET_CYCLES = 2;
  // one transfer plus margin for the strobes around it
  localparam int XFER_CYCLES  = 16 * `SPI_HALF_PERIOD + 10;
  localparam     GOLDEN_PATH  = "tb/spi_loop_golden.txt";

  logic         clk;
  logic         RST;
  logic         send;
  logic [W-1:0] data_in;
  logic [W-1:0] data_out;
  logic         data_valid;
  reply_order_e select;
  logic         loop_mode;
  logic         ext_master_mosi;
  logic         ext_master_miso;
  logic         ext_master_sclk;
  logic         ext_master_cs;
  logic         ext_slave_mosi;
  logic         ext_slave_miso;
  logic         ext_slave_sclk;
  logic         ext_slave_cs;

  // expectation strobe and results of the checker
  logic            exp_push;
  logic [W-1:0]    exp_data;
  logic [8*16-1:0] exp_name;
  int              exp_index;
  logic            final_check;
  int              error_count;
  int              check_count;

  // golden lines, one entry per transfer
  logic            mode_q[$];
  reply_order_e    sel_q[$];
  logic [W-1:0]    din_q[$];
  logic [W-1:0]    dout_q[$];
  logic            busy_q[$];
  logic [8*16-1:0] group_q[$];
  int              index_q[$];

  int cycle_count = 0;
  int cycle_limit = 0;
  bit golden_ok;

  initial clk = 1'b0;
  always #2 clk = ~clk;

  spi_loop dut_i (
    .clk             (clk),
    .RST             (RST),
    .send            (send),
    .data_in         (data_in),
    .data_out        (data_out),
    .data_valid      (data_valid),
    .select          (select),
    .loop_mode       (loop_mode),
    .ext_master_mosi (ext_master_mosi),
    .ext_master_miso (ext_master_miso),
    .ext_master_sclk (ext_master_sclk),
    .ext_master_cs   (ext_master_cs),
    .ext_slave_mosi  (ext_slave_mosi),
    .ext_slave_miso  (ext_slave_miso),
    .ext_slave_sclk  (ext_slave_sclk),
    .ext_slave_cs    (ext_slave_cs)
  );

  spi_loop_checker check_i (
    .clk          (clk),
    .RST          (RST),
    .data_valid   (data_valid),
    .data_out     (data_out),
    .master_state (dut_i.master_i.state),
    .exp_push     (exp_push),
    .exp_data     (exp_data),
    .exp_name     (exp_name),
    .exp_index    (exp_index),
    .final_check  (final_check),
    .error_count  (error_count),
    .check_count  (check_count)
  );

  // external loop on the pins when loop_mode is 0
  // idle levels otherwise
  assign ext_slave_mosi  = loop_mode ? 1'b0 : ext_master_mosi;
  assign ext_slave_sclk  = loop_mode ? 1'b0 : ext_master_sclk;
  assign ext_slave_cs    = loop_mode ? 1'b1 : ext_master_cs;
  assign ext_master_miso = loop_mode ? 1'b0 : ext_slave_miso;

  // run limit
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("timeout: run still busy after %0d cycles, data_valid missing", cycle_limit);
      $display("Checks failed");
      $finish;
    end
  end

  task automatic read_golden(output bit ok);
    int              fd;
    int              n;
    int              line_no;
    int              idx;
    string           line;
    logic [8*16-1:0] group;
    logic [31:0]     f_mode;
    logic [31:0]     f_sel;
    logic [31:0]     f_din;
    logic [31:0]     f_dout;
    logic [31:0]     f_busy;
    ok      = 1'b1;
    line_no = 0;
    idx     = 0;
    group   = "unnamed";
    fd      = $fopen(GOLDEN_PATH, "r");
    if (fd == 0) begin
      ok = 1'b0;
    end else begin
      while (ok && $fgets(line, fd) > 0) begin
        line_no++;
        if (line.len() < 2 || line.getc(0) == "#") begin
          // blank or comment
        end else if (line.getc(0) == "@") begin
          // new group name, numbering restarts
          n   = $sscanf(line, "@ %s", group);
          idx = 0;
        end else begin
          n = $sscanf(line, "%h %h %h %h %h", f_mode, f_sel, f_din, f_dout, f_busy);
          if (n != 5) begin
            $display("golden line %0d is malformed: %s", line_no, line);
            ok = 1'b0;
          end else begin
            mode_q.push_back(f_mode[0]);
            sel_q.push_back(reply_order_e'(f_sel[0]));
            din_q.push_back(f_din[W-1:0]);
            dout_q.push_back(f_dout[W-1:0]);
            busy_q.push_back(f_busy[0]);
            group_q.push_back(group);
            index_q.push_back(idx);
            idx++;
          end
        end
      end
      $fclose(fd);
    end
    if (ok && mode_q.size() == 0) begin
      $display("golden file holds no transfers");
      ok = 1'b0;
    end
  endtask

  // data_valid sampled on the falling edge
  task automatic wait_valid();
    while (data_valid !== 1'b1) begin
      @(negedge clk);
    end
  endtask

  task automatic run_transfer(input int i);
    @(negedge clk);
    loop_mode = mode_q[i];
    select    = sel_q[i];
    data_in   = din_q[i];
    send      = 1'b1;
    exp_push  = 1'b1;
    exp_data  = dout_q[i];
    exp_name  = group_q[i];
    exp_index = index_q[i];
    @(negedge clk);
    send     = 1'b0;
    exp_push = 1'b0;
    if (busy_q[i]) begin
      // second strobe mid-transfer with other data, must be dropped
      repeat (2 * `SPI_HALF_PERIOD) @(negedge clk);
      data_in = ~din_q[i];
      send    = 1'b1;
      @(negedge clk);
      send = 1'b0;
    end
    wait_valid();
  endtask

  initial begin
    RST         = 1'b1;
    send        = 1'b0;
    data_in     = '0;
    select      = order_direct;
    loop_mode   = 1'b1;
    exp_push    = 1'b0;
    exp_data    = '0;
    exp_name    = '0;
    exp_index   = 0;
    final_check = 1'b0;
    read_golden(golden_ok);
    if (!golden_ok) begin
      $display("golden file %0s could not be used", GOLDEN_PATH);
      $display("Checks failed");
      $finish;
    end else begin
      cycle_limit = (mode_q.size() + 2) * XFER_CYCLES + RESET_CYCLES;
      repeat (RESET_CYCLES) @(negedge clk);
      RST = 1'b0;
      for (int i = 0; i < mode_q.size(); i++) begin
        run_transfer(i);
      end
      // ask the checker for leftovers, then let it settle
      @(negedge clk);
      final_check = 1'b1;
      @(negedge clk);
      final_check = 1'b0;
      repeat (2) @(negedge clk);
      $display("summary: %0d transfers checked, %0d errors", check_count, error_count);
      if (error_count == 0) begin
        $display("All checks passed");
      end else begin
        $display("Checks failed");
      end
      $finish;
    end
  end

endmodule

// File: tb/spi_loop_golden.txt
# columns, hex: loop_mode select data_in expected_data_out busy_send
# expected is the previous data_in, bit-reversed when its select was 1
@ after_reset
1 0 3C 00 0
@ direct_internal
1 0 11 3C 0
1 0 22 11 0
1 0 7E 22 0
1 0 FF 7E 0
1 0 00 FF 0
@ reverse_internal
1 1 01 00 0
1 1 80 80 0
1 1 0F 01 0
1 1 A5 F0 0
1 1 C3 A5 0
1 1 12 C3 0
@ external_direct
0 0 5A 48 0
0 0 3C 5A 0
0 1 96 3C 0
0 1 E0 69 0
0 0 81 07 0
@ busy_send
1 0 D4 81 1
1 1 36 D4 1
0 0 B7 6C 1
@ mode_switch
1 0 9C B7 0
0 0 4E 9C 0
1 1 2B 4E 0
0 0 E7 D4 0
1 0 00 E7 0

// File: Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_spi_loop
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
PASS_MSG  = All checks passed

SOURCES = $(wildcard design/*.sv design/*.svh tb/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# exit status comes from the grep
run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: vlog.f
+incdir+design
design/spi_loop_pkg.sv
design/spi_master.sv
design/spi_slave.sv
design/spi_loop.sv
tb/spi_loop_checker.sv
tb/tb_spi_loop.sv
